// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --timing --assert -Wno-fatal
TOP       := xbar_arb_tb
RTL_TOP   := xbar_input_arbiter
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := test passed

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter-out xbar_arb_tb%.sv,$(SRCS))
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
xbar_arb_pkg.sv
vc_pick_if.sv
vc_eligibility.sv
prio_rr_picker.sv
input_port_arbiter.sv
xbar_input_arbiter.sv
xbar_arb_tb_checks.sv
xbar_arb_tb.sv

// ==== input_port_arbiter.sv ====
`timescale 1ns/100ps

module input_port_arbiter (
  input  logic                   clk,
  input  logic                   resetn,
  vc_pick_if.arbiter             hi,
  vc_pick_if.arbiter             lo,
  input  xbar_arb_pkg::dest_t    dest_i             [xbar_arb_pkg::VC_TOTAL-1:0],
  input  xbar_arb_pkg::vc_idx_t  out_vc_i           [xbar_arb_pkg::VC_TOTAL-1:0],
  input  xbar_arb_pkg::vc_mask_t credit_i           [xbar_arb_pkg::OUTPUT_NUM-1:0],
  input  xbar_arb_pkg::vc_mask_t grant_i            [xbar_arb_pkg::OUTPUT_NUM-1:0],
  input  logic                   last_i,
  output xbar_arb_pkg::vc_mask_t selected_request_o [xbar_arb_pkg::OUTPUT_NUM-1:0],
  output logic                   cts_o,
  output xbar_arb_pkg::vc_idx_t  selected_vc_o
);
  import xbar_arb_pkg::*;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    REQ  = 2'd1,
    XFER = 2'd2
  } state_t;

  state_t  state_q;
  // winner came from the high priority picker
  logic    hi_won_q;
  // destination and output vc of the vc in session
  dest_t   dest_q;
  vc_idx_t ovc_q;

  // winner of the current cycle
  logic    take_hi;
  logic    pick_any;
  vc_idx_t win_vc;
  dest_t   win_dest;
  vc_idx_t win_ovc;

  // credit, grant and request bits at the latched crossing point
  logic cur_credit;
  logic cur_grant;
  logic cur_req;
  logic end_of_pkt;

  // high priority always beats low
  assign take_hi  = hi.pick_valid;
  assign pick_any = hi.pick_valid | lo.pick_valid;

  always_comb begin
    int         base;
    lane_t      lane;
    lane_mask_t seen;
    base     = take_hi ? VC_NUM : 0;
    lane     = take_hi ? hi.pick_lane : lo.pick_lane;
    seen     = take_hi ? hi.lane_req_seen : lo.lane_req_seen;
    win_vc   = take_hi ? vc_idx_t'(VC_NUM) + vc_idx_t'(lane) : vc_idx_t'(lane);
    win_dest = '0;
    win_ovc  = '0;
    // one-hot and-or mux over the lanes of the winning priority
    for (int l = 0; l < VC_NUM; l++) begin
      if (seen[l]) begin
        win_dest = win_dest | dest_i[base + l];
        win_ovc  = win_ovc | out_vc_i[base + l];
      end
    end
  end

  assign cur_credit = credit_i[dest_q][ovc_q];
  assign cur_grant  = grant_i[dest_q][ovc_q];
  assign cur_req    = selected_request_o[dest_q][ovc_q];
  assign end_of_pkt = (state_q == XFER) && last_i;

  // pointer update goes to the priority that owned the packet
  // it lands on the same edge that ends the session
  assign hi.advance = end_of_pkt & hi_won_q;
  assign lo.advance = end_of_pkt & ~hi_won_q;

  // session payload, loaded when a vc is taken
  always_ff @(posedge clk) begin
    if (state_q == IDLE && pick_any) begin
      dest_q <= win_dest;
      ovc_q  <= win_ovc;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state_q       <= IDLE;
      hi_won_q      <= 1'b0;
      cts_o         <= 1'b0;
      selected_vc_o <= '0;
      for (int o = 0; o < OUTPUT_NUM; o++) begin
        selected_request_o[o] <= '0;
      end
    end else begin
      case (state_q)
        IDLE: begin
          if (pick_any) begin
            state_q       <= REQ;
            hi_won_q      <= take_hi;
            selected_vc_o <= win_vc;
          end
        end
        REQ: begin
          // credit lost before grant, withdraw without advancing
          if (!cur_credit) begin
            state_q                           <= IDLE;
            selected_request_o[dest_q][ovc_q] <= 1'b0;
          end else if (cur_grant && cur_req) begin
            state_q <= XFER;
            cts_o   <= 1'b1;
          end else begin
            // request shows one cycle after the vc was taken
            selected_request_o[dest_q][ovc_q] <= 1'b1;
          end
        end
        XFER: begin
          // credits are not looked at here, only last ends the packet
          if (last_i) begin
            state_q                           <= IDLE;
            cts_o                             <= 1'b0;
            selected_request_o[dest_q][ovc_q] <= 1'b0;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // flat copy of the request matrix for the one-hot check
  logic [OUTPUT_NUM*VC_TOTAL-1:0] sel_flat;

  always_comb begin
    for (int o = 0; o < OUTPUT_NUM; o++) begin
      sel_flat[o*VC_TOTAL +: VC_TOTAL] = selected_request_o[o];
    end
  end

  a_one_request : assert property (
    @(posedge clk) disable iff (!resetn)
    $onehot0(sel_flat)
  ) else $error("more than one selected_request bit set");

  // the output arbiter keeps its grant up for the whole packet
  a_cts_has_grant : assert property (
    @(posedge clk) disable iff (!resetn)
    cts_o |-> cur_grant
  ) else $error("cts high without grant on the selected bit");

  a_last_in_xfer : assert property (
    @(posedge clk) disable iff (!resetn)
    last_i |-> (state_q == XFER)
  ) else $error("last outside a transfer");

endmodule

// ==== prio_rr_picker.sv ====
`timescale 1ns/100ps

module prio_rr_picker (
  input logic         clk,
  input logic         resetn,
  vc_pick_if.picker   pick
);
  import xbar_arb_pkg::*;

  // lane served last in this priority
  lane_t last_q;

  // round-robin search, starting one lane past last_q and wrapping
  always_comb begin
    int   idx;
    logic found;
    found          = 1'b0;
    idx            = 0;
    pick.pick_lane = '0;
    for (int i = 1; i <= VC_NUM; i++) begin
      idx = (int'(last_q) + i) % VC_NUM;
      // first hit wins, later lanes are ignored
      if (!found && pick.lane_req[idx]) begin
        found          = 1'b1;
        pick.pick_lane = lane_t'(idx);
      end
    end
  end

  assign pick.pick_valid = |pick.lane_req;

  // one-hot view of the pick, used by the port side as a mux select
  assign pick.lane_req_seen = pick.pick_valid ? (lane_mask_t'(1) << pick.pick_lane) : '0;

  // pointer moves only when a packet of this priority has finished
  // reset value is the top lane so lane 0 comes first
  always_ff @(posedge clk) begin
    if (!resetn) begin
      last_q <= lane_t'(VC_NUM - 1);
    end else if (pick.advance) begin
      last_q <= pick.pick_lane;
    end
  end

  // an advance with nothing requesting would store a stale lane
  a_advance_needs_pick : assert property (
    @(posedge clk) disable iff (!resetn)
    pick.advance |-> pick.pick_valid
  ) else $error("advance without a valid pick");

endmodule

// ==== vc_eligibility.sv ====
`timescale 1ns/100ps

module vc_eligibility (
  input  xbar_arb_pkg::vc_mask_t   has_packet_i,
  input  xbar_arb_pkg::dest_t      dest_i     [xbar_arb_pkg::VC_TOTAL-1:0],
  input  xbar_arb_pkg::vc_idx_t    out_vc_i   [xbar_arb_pkg::VC_TOTAL-1:0],
  input  xbar_arb_pkg::vc_mask_t   credit_i   [xbar_arb_pkg::OUTPUT_NUM-1:0],
  output xbar_arb_pkg::lane_mask_t hi_req_o,
  output xbar_arb_pkg::lane_mask_t lo_req_o
);
  import xbar_arb_pkg::*;

  // per vc request, flat index order
  vc_mask_t eligible;

  always_comb begin
    vc_mask_t out_vc_ok;
    vc_mask_t credit_ok;
    for (int v = 0; v < VC_TOTAL; v++) begin
      // an output vc beyond the last one has no credit bit at all
      out_vc_ok[v] = (out_vc_i[v] < vc_idx_t'(VC_TOTAL));
      // credit of the output fifo this vc is heading to
      credit_ok[v] = out_vc_ok[v] & credit_i[dest_i[v]][out_vc_i[v]];
      // packet waiting and room downstream
      eligible[v] = has_packet_i[v] & credit_ok[v];
    end
  end

  // flat 0..2 is the low priority, 3..5 the high one
  assign lo_req_o = eligible[0 +: VC_NUM];
  assign hi_req_o = eligible[VC_NUM +: VC_NUM];

endmodule

// ==== vc_pick_if.sv ====
`timescale 1ns/100ps

interface vc_pick_if;
  import xbar_arb_pkg::*;

  // lanes of this priority that may request now
  lane_mask_t lane_req;
  // some lane requests
  logic       pick_valid;
  // next requesting lane after the last served one
  lane_t      pick_lane;
  // one-hot copy of pick_lane, zero when nothing requests
  lane_mask_t lane_req_seen;
  // end of a served packet, picker moves its pointer
  logic       advance;

  modport picker (
    input  lane_req,
    input  advance,
    output pick_valid,
    output pick_lane,
    output lane_req_seen
  );

  modport arbiter (
    input  pick_valid,
    input  pick_lane,
    input  lane_req_seen,
    output advance
  );

endinterface

// ==== xbar_arb_pkg.sv ====
package xbar_arb_pkg;

  // switch geometry
  localparam int PRIO_NUM   = 2;
  localparam int VC_NUM     = 3;
  localparam int VC_TOTAL   = PRIO_NUM * VC_NUM;
  localparam int OUTPUT_NUM = 8;

  // field widths
  localparam int VC_IDX_W = 3;
  localparam int DEST_W   = 3;
  localparam int LANE_W   = 2;

  // flat vc index, priority * VC_NUM + lane
  // low priority sits on 0..2, high priority on 3..5
  typedef logic [VC_IDX_W-1:0] vc_idx_t;

  // crossbar output number
  typedef logic [DEST_W-1:0] dest_t;

  // lane inside one priority
  typedef logic [LANE_W-1:0] lane_t;

  // one bit per flat vc
  // credits, grants and selected_request rows are arrays of these, one per output
  typedef logic [VC_TOTAL-1:0] vc_mask_t;

  // one bit per lane of a single priority
  typedef logic [VC_NUM-1:0] lane_mask_t;

endpackage

// ==== xbar_arb_tb.sv ====
`timescale 1ns/100ps

module xbar_arb_tb;
  import xbar_arb_pkg::*;

  typedef enum {OA_IDLE, OA_WAIT, OA_HOLD, OA_LAST} oa_state_t;

  logic     clk = 1'b0;
  logic     resetn;
  vc_mask_t has_packet;
  dest_t    dest    [VC_TOTAL-1:0];
  vc_idx_t  out_vc  [VC_TOTAL-1:0];
  vc_mask_t credit  [OUTPUT_NUM-1:0];
  vc_mask_t grant   [OUTPUT_NUM-1:0];
  logic     last;
  vc_mask_t sel_req [OUTPUT_NUM-1:0];
  logic     cts;
  vc_idx_t  sel_vc;

  logic [127:0] test_name;
  int           seed = 81448;
  int           chk_errs;
  int           tb_errs;
  int           mark;
  int           tests_run;
  int           tests_bad;
  // output arbiter model state
  oa_state_t    oa_state;
  int           oa_cnt;
  dest_t        oa_dest;
  vc_idx_t      oa_ovc;
  logic         hold_grant;
  logic         wiggle_credit;
  // packets left per vc, finished sessions in order
  int           pkts [VC_TOTAL];
  int           sessions_done;
  vc_idx_t      served [$];
  vc_idx_t      rr_order [8];

  always #2 clk = ~clk;

  xbar_input_arbiter UUT (
    .clk (clk), .resetn (resetn), .has_packet_i (has_packet), .dest_i (dest),
    .out_vc_i (out_vc), .credit_i (credit), .grant_i (grant), .last_i (last),
    .selected_request_o (sel_req), .cts_o (cts), .selected_vc_o (sel_vc)
  );

  xbar_arb_tb_checks u_checks (
    .clk (clk), .resetn (resetn), .test_name_i (test_name), .has_packet_i (has_packet),
    .dest_i (dest), .out_vc_i (out_vc), .credit_i (credit), .grant_i (grant),
    .last_i (last), .selected_request_i (sel_req), .cts_i (cts), .selected_vc_i (sel_vc),
    .err_cnt_o (chk_errs)
  );

  function automatic logic request_up();
    logic any;
    any = 1'b0;
    for (int o = 0; o < OUTPUT_NUM; o++) begin
      any = any | (|sel_req[o]);
    end
    return any;
  endfunction

  // one falling edge and then one step of the output arbiter
  task automatic tick();
    @(negedge clk);
    case (oa_state)
      OA_IDLE: begin
        for (int o = 0; o < OUTPUT_NUM; o++) begin
          for (int v = 0; v < VC_TOTAL; v++) begin
            if (sel_req[o][v] && !hold_grant) begin
              oa_dest  = dest_t'(o);
              oa_ovc   = vc_idx_t'(v);
              oa_cnt   = $unsigned($random(seed)) % 4;
              oa_state = OA_WAIT;
            end
          end
        end
      end
      OA_WAIT: begin
        // request withdrawn so there is nothing to grant
        if (!sel_req[oa_dest][oa_ovc]) begin
          oa_state = OA_IDLE;
        end else if (oa_cnt == 0) begin
          grant[oa_dest][oa_ovc] = 1'b1;
          oa_cnt                 = 1 + $unsigned($random(seed)) % 5;
          oa_state               = OA_HOLD;
        end else begin
          oa_cnt--;
        end
      end
      OA_HOLD: begin
        if (oa_cnt == 0) begin
          // credit is back in place when the packet ends
          credit[oa_dest][oa_ovc] = credit[oa_dest][oa_ovc] | wiggle_credit;
          last     = 1'b1;
          oa_state = OA_LAST;
        end else begin
          // credit noise while the packet moves
          if (wiggle_credit) begin
            credit[oa_dest][oa_ovc] = 1'($random(seed));
          end
          oa_cnt--;
        end
      end
      default: begin
        last                   = 1'b0;
        grant[oa_dest][oa_ovc] = 1'b0;
        served.push_back(sel_vc);
        if (pkts[sel_vc] > 0) begin
          pkts[sel_vc]--;
        end
        has_packet[sel_vc] = (pkts[sel_vc] > 0);
        sessions_done++;
        oa_state = OA_IDLE;
      end
    endcase
  endtask

  task automatic apply_reset();
    resetn   = 1'b0;
    oa_state = OA_IDLE;
    last     = 1'b0;
    for (int o = 0; o < OUTPUT_NUM; o++) begin
      grant[o] = '0;
    end
    repeat (8) tick();
    resetn = 1'b1;
  endtask

  // random destinations, distinct output vcs, credit only where a vc points
  task automatic set_routes();
    int r;
    r = $unsigned($random(seed)) % VC_TOTAL;
    for (int o = 0; o < OUTPUT_NUM; o++) begin
      credit[o] = '0;
    end
    for (int v = 0; v < VC_TOTAL; v++) begin
      dest[v]   = dest_t'($random(seed));
      out_vc[v] = vc_idx_t'((v + r) % VC_TOTAL);
      credit[dest[v]][out_vc[v]] = 1'b1;
    end
  endtask

  task automatic run_sessions(int n, int limit);
    int target;
    int cnt;
    target = sessions_done + n;
    cnt    = 0;
    while (sessions_done < target && cnt < limit) begin
      tick();
      cnt++;
    end
    if (sessions_done < target) begin
      $display("%0s: timed out waiting for %0d packets to finish", test_name, n);
      tb_errs++;
    end
  endtask

  task automatic wait_request(logic want, int limit);
    int cnt;
    cnt = 0;
    while (request_up() != want && cnt < limit) begin
      tick();
      cnt++;
    end
    if (request_up() != want) begin
      $display("%0s: timed out waiting for selected_request to change", test_name);
      tb_errs++;
    end
  endtask

  task automatic start_test(logic [127:0] name);
    test_name = name;
    mark      = chk_errs + tb_errs;
  endtask

  task automatic finish_test();
    int errs;
    errs = chk_errs + tb_errs - mark;
    tests_run++;
    if (errs != 0) begin
      tests_bad++;
      $display("%0s: %0d errors", test_name, errs);
    end else begin
      $display("%0s: ok", test_name);
    end
  endtask

  initial begin
    int total;
    resetn        = 1'b0;
    last          = 1'b0;
    has_packet    = '0;
    hold_grant    = 1'b0;
    wiggle_credit = 1'b0;
    oa_state      = OA_IDLE;
    sessions_done = 0;
    tb_errs       = 0;
    tests_run     = 0;
    tests_bad     = 0;
    for (int v = 0; v < VC_TOTAL; v++) begin
      dest[v]   = '0;
      out_vc[v] = '0;
      pkts[v]   = 0;
    end
    for (int o = 0; o < OUTPUT_NUM; o++) begin
      credit[o] = '0;
      grant[o]  = '0;
    end

    start_test("reset");
    apply_reset();
    repeat (2) tick();
    finish_test();

    // vc 1 low against vc 4 high
    start_test("priority");
    set_routes();
    pkts[1]    = 1;
    pkts[4]    = 1;
    has_packet = 6'b010010;
    run_sessions(2, 200);
    finish_test();

    // fresh pointers and then both priorities loaded at once
    start_test("round_robin");
    apply_reset();
    set_routes();
    pkts       = '{2, 1, 1, 2, 1, 1};
    rr_order   = '{3'd3, 3'd4, 3'd5, 3'd3, 3'd0, 3'd1, 3'd2, 3'd0};
    has_packet = '1;
    served.delete();
    run_sessions(8, 400);
    for (int i = 0; i < 8; i++) begin
      assert (i < served.size() && served[i] == rr_order[i]) else begin
        $display("ERR %0s order[%0d] expected %0d actual %0d", test_name, i, rr_order[i],
                 (i < served.size()) ? served[i] : vc_idx_t'(7));
        tb_errs++;
      end
    end
    finish_test();

    // vc 2 without credit while vc 1 loses its credit waiting for grant
    start_test("credit_gating");
    set_routes();
    pkts[1]    = 1;
    pkts[2]    = 1;
    hold_grant = 1'b1;
    credit[dest[2]][out_vc[2]] = 1'b0;
    has_packet = 6'b000110;
    wait_request(1'b1, 50);
    repeat (3) tick();
    credit[dest[1]][out_vc[1]] = 1'b0;
    wait_request(1'b0, 20);
    repeat (2) tick();
    credit[dest[1]][out_vc[1]] = 1'b1;
    credit[dest[2]][out_vc[2]] = 1'b1;
    hold_grant = 1'b0;
    run_sessions(2, 200);
    finish_test();

    start_test("session");
    set_routes();
    total = 0;
    for (int v = 0; v < VC_TOTAL; v++) begin
      pkts[v] = 1 + $unsigned($random(seed)) % 2;
      total   = total + pkts[v];
    end
    wiggle_credit = 1'b1;
    has_packet    = '1;
    run_sessions(total, 1000);
    wiggle_credit = 1'b0;
    finish_test();

    $display("tests %0d, failing %0d, errors %0d", tests_run, tests_bad, chk_errs + tb_errs);
    if (chk_errs + tb_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== xbar_arb_tb_checks.sv ====
`timescale 1ns/100ps

module xbar_arb_tb_checks (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic [127:0]           test_name_i,
  input  xbar_arb_pkg::vc_mask_t has_packet_i,
  input  xbar_arb_pkg::dest_t    dest_i             [xbar_arb_pkg::VC_TOTAL-1:0],
  input  xbar_arb_pkg::vc_idx_t  out_vc_i           [xbar_arb_pkg::VC_TOTAL-1:0],
  input  xbar_arb_pkg::vc_mask_t credit_i           [xbar_arb_pkg::OUTPUT_NUM-1:0],
  input  xbar_arb_pkg::vc_mask_t grant_i            [xbar_arb_pkg::OUTPUT_NUM-1:0],
  input  logic                   last_i,
  input  xbar_arb_pkg::vc_mask_t selected_request_i [xbar_arb_pkg::OUTPUT_NUM-1:0],
  input  logic                   cts_i,
  input  xbar_arb_pkg::vc_idx_t  selected_vc_i,
  output int                     err_cnt_o
);
  import xbar_arb_pkg::*;

  typedef enum logic [1:0] {M_IDLE, M_REQ, M_XFER} model_state_t;

  // reference session state and its latched vc
  model_state_t m_state;
  logic         m_req_up;
  vc_idx_t      exp_vc;
  dest_t        exp_dest;
  vc_idx_t      exp_ovc;
  // last served lane, index 1 is the high priority
  lane_t        last_lane [PRIO_NUM-1:0];
  logic         in_reset_q = 1'b0;
  int           errs = 0;

  vc_mask_t                       elig;
  logic [OUTPUT_NUM*VC_TOTAL-1:0] sel_flat;
  logic [OUTPUT_NUM*VC_TOTAL-1:0] exp_flat;
  logic                           credit_here;
  logic                           grant_here;

  assign err_cnt_o = errs;

  task automatic report_mismatch(string what, longint expected, longint actual);
    $display("ERR %0s %0s expected %0h actual %0h", test_name_i, what, expected, actual);
    errs++;
  endtask

  // walk the lanes of the winning priority, starting past its last served lane
  function automatic vc_idx_t next_vc(vc_mask_t req, lane_t hi_last, lane_t lo_last);
    lane_mask_t lanes;
    int         lane;
    int         base;
    logic       found;
    base    = (|req[2*VC_NUM-1:VC_NUM]) ? VC_NUM : 0;
    lanes   = req[base +: VC_NUM];
    lane    = (base != 0) ? int'(hi_last) : int'(lo_last);
    found   = 1'b0;
    next_vc = '0;
    repeat (VC_NUM) begin
      lane = (lane + 1) % VC_NUM;
      if (!found && lanes[lane]) begin
        found   = 1'b1;
        next_vc = vc_idx_t'(base + lane);
      end
    end
  endfunction

  always_comb begin
    // packet present and credit at its crossing point
    for (int v = 0; v < VC_TOTAL; v++) begin
      elig[v] = has_packet_i[v] & credit_i[dest_i[v]][out_vc_i[v]];
    end
    for (int o = 0; o < OUTPUT_NUM; o++) begin
      sel_flat[o*VC_TOTAL +: VC_TOTAL] = selected_request_i[o];
    end
    exp_flat = '0;
    if (m_state == M_XFER || (m_state == M_REQ && m_req_up)) begin
      exp_flat[int'(exp_dest)*VC_TOTAL + int'(exp_ovc)] = 1'b1;
    end
  end

  assign credit_here = credit_i[exp_dest][exp_ovc];
  assign grant_here  = grant_i[exp_dest][exp_ovc];

  always @(posedge clk) begin
    in_reset_q <= !resetn;
  end

  always @(posedge clk) begin
    vc_idx_t pick;
    pick = next_vc(elig, last_lane[1], last_lane[0]);
    if (!resetn) begin
      m_state      <= M_IDLE;
      m_req_up     <= 1'b0;
      exp_vc       <= '0;
      exp_dest     <= '0;
      exp_ovc      <= '0;
      last_lane[0] <= lane_t'(VC_NUM - 1);
      last_lane[1] <= lane_t'(VC_NUM - 1);
    end else begin
      case (m_state)
        M_IDLE: begin
          if (|elig) begin
            m_state  <= M_REQ;
            m_req_up <= 1'b0;
            exp_vc   <= pick;
            exp_dest <= dest_i[pick];
            exp_ovc  <= out_vc_i[pick];
          end
        end
        M_REQ: begin
          // credit gone before grant, no pointer move
          if (!credit_here) begin
            m_state <= M_IDLE;
          end else if (grant_here && m_req_up) begin
            m_state <= M_XFER;
          end else begin
            m_req_up <= 1'b1;
          end
        end
        default: begin
          // pointer moves on the edge where cts_o falls
          if (last_i) begin
            m_state                        <= M_IDLE;
            last_lane[exp_vc >= VC_NUM] <= lane_t'(exp_vc % VC_NUM);
          end
        end
      endcase
    end
  end

  a_reset_quiet : assert property (
    @(posedge clk) in_reset_q |-> (sel_flat == '0 && !cts_i && selected_vc_i == '0)
  ) else report_mismatch("reset outputs", 0,
      {$sampled(selected_vc_i), $sampled(cts_i), $sampled(sel_flat)});

  a_vc_choice : assert property (
    @(posedge clk) disable iff (!resetn)
    m_state != M_IDLE |-> selected_vc_i == exp_vc
  ) else report_mismatch("selected_vc", $sampled(exp_vc), $sampled(selected_vc_i));

  a_request_bit : assert property (
    @(posedge clk) disable iff (!resetn)
    sel_flat == exp_flat
  ) else report_mismatch("selected_request", $sampled(exp_flat), $sampled(sel_flat));

  a_cts_level : assert property (
    @(posedge clk) disable iff (!resetn)
    cts_i == (m_state == M_XFER)
  ) else report_mismatch("cts", $sampled(m_state == M_XFER), $sampled(cts_i));

  // grant seen on the request bit, cts follows one cycle later
  a_cts_rise : assert property (
    @(posedge clk) disable iff (!resetn)
    (m_state == M_REQ && m_req_up && grant_here && credit_here) |=> cts_i
  ) else report_mismatch("cts after grant", 1, $sampled(cts_i));

  a_cts_fall : assert property (
    @(posedge clk) disable iff (!resetn)
    (cts_i && last_i) |=> (!cts_i && sel_flat == '0)
  ) else report_mismatch("cts after last", 0, {$sampled(cts_i), $sampled(sel_flat)});

endmodule

// ==== xbar_input_arbiter.sv ====
`timescale 1ns/100ps

module xbar_input_arbiter (
  input  logic                   clk,
  input  logic                   resetn,
  input  xbar_arb_pkg::vc_mask_t has_packet_i,
  input  xbar_arb_pkg::dest_t    dest_i             [xbar_arb_pkg::VC_TOTAL-1:0],
  input  xbar_arb_pkg::vc_idx_t  out_vc_i           [xbar_arb_pkg::VC_TOTAL-1:0],
  input  xbar_arb_pkg::vc_mask_t credit_i           [xbar_arb_pkg::OUTPUT_NUM-1:0],
  input  xbar_arb_pkg::vc_mask_t grant_i            [xbar_arb_pkg::OUTPUT_NUM-1:0],
  input  logic                   last_i,
  output xbar_arb_pkg::vc_mask_t selected_request_o [xbar_arb_pkg::OUTPUT_NUM-1:0],
  output logic                   cts_o,
  output xbar_arb_pkg::vc_idx_t  selected_vc_o
);

  // one bundle per priority between its picker and the port arbiter
  vc_pick_if hi_pick ();
  vc_pick_if lo_pick ();

  // which vcs may request, split per priority
  vc_eligibility u_elig (
    .has_packet_i (has_packet_i),
    .dest_i       (dest_i),
    .out_vc_i     (out_vc_i),
    .credit_i     (credit_i),
    .hi_req_o     (hi_pick.lane_req),
    .lo_req_o     (lo_pick.lane_req)
  );

  // high priority lanes, flat vcs 3..5
  prio_rr_picker u_hi_picker (
    .clk    (clk),
    .resetn (resetn),
    .pick   (hi_pick.picker)
  );

  // low priority lanes, flat vcs 0..2
  prio_rr_picker u_lo_picker (
    .clk    (clk),
    .resetn (resetn),
    .pick   (lo_pick.picker)
  );

  // priority choice and the request/grant/transfer session
  input_port_arbiter u_port_arb (
    .clk                (clk),
    .resetn             (resetn),
    .hi                 (hi_pick.arbiter),
    .lo                 (lo_pick.arbiter),
    .dest_i             (dest_i),
    .out_vc_i           (out_vc_i),
    .credit_i           (credit_i),
    .grant_i            (grant_i),
    .last_i             (last_i),
    .selected_request_o (selected_request_o),
    .cts_o              (cts_o),
    .selected_vc_o      (selected_vc_o)
  );

endmodule
